// File: verilog/isa_pkg.sv
// Instruction set of the core: sizes, opcodes, function codes and the instruction word
// Imported by the fetch and decode stages and by the testbench reference model
package isa_pkg;

	// Datapath and storage sizes
	localparam int word_w     = 16;
	localparam int reg_addr_w = 3;
	localparam int imem_depth = 256;
	localparam int dmem_depth = 256;
	localparam int mem_addr_w = 8;

	// Field widths
	localparam int op_w  = 5;
	localparam int fn_w  = 2;
	localparam int imm_w = 5;

	// Opcodes
	localparam logic [op_w-1:0] op_halt  = 5'b00000;
	localparam logic [op_w-1:0] op_nop   = 5'b00001;
	localparam logic [op_w-1:0] op_addi  = 5'b01000;
	localparam logic [op_w-1:0] op_subi  = 5'b01001;
	localparam logic [op_w-1:0] op_xori  = 5'b01010;
	localparam logic [op_w-1:0] op_andni = 5'b01011;
	localparam logic [op_w-1:0] op_st    = 5'b10000;
	localparam logic [op_w-1:0] op_ld    = 5'b10001;
	localparam logic [op_w-1:0] op_rrr   = 5'b11011;

	// Function field of the register-register group
	localparam logic [fn_w-1:0] fn_add  = 2'b00;
	localparam logic [fn_w-1:0] fn_sub  = 2'b01;
	localparam logic [fn_w-1:0] fn_xor  = 2'b10;
	localparam logic [fn_w-1:0] fn_andn = 2'b11;

	typedef struct packed {
		logic [op_w-1:0]       opcode;
		logic [reg_addr_w-1:0] rs;
		logic [reg_addr_w-1:0] rt;
		logic [reg_addr_w-1:0] rd;
		logic [fn_w-1:0]       funct;
	} r_fmt_t;

	// Also used by LD and ST, where rd is the data register
	typedef struct packed {
		logic [op_w-1:0]       opcode;
		logic [reg_addr_w-1:0] rs;
		logic [reg_addr_w-1:0] rd;
		logic [imm_w-1:0]      imm;
	} i_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_t;

endpackage

// File: verilog/pipe_pkg.sv
// Encodings carried between the pipeline stages
// Decode produces them, execute and result consume them
package pipe_pkg;

	// ALU operation, A is the rs operand and B the immediate or rt operand
	typedef enum logic [1:0] {
		// A + B, also the LD/ST address
		alu_add     = 2'b00,
		// B - A, so SUBI gives immediate minus rs
		alu_sub_rev = 2'b01,
		alu_xor     = 2'b10,
		// A and not B
		alu_andn    = 2'b11
	} alu_op_t;

	// Source of the value written back to the register file
	typedef enum logic {
		res_alu = 1'b0,
		// Data memory read at the ALU address
		res_mem = 1'b1
	} res_src_t;

endpackage

// File: verilog/fetch.sv
// Fetch stage with the PC, instruction memory and the fetch/decode register
// The memory is loaded through the program port while rst is held
module fetch (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           prog_we,
	input  logic [isa_pkg::mem_addr_w-1:0] prog_addr,
	input  isa_pkg::instr_t                prog_data,
	input  logic                           halt_seen,
	output logic                           fd_valid,
	output isa_pkg::instr_t                fd_instr
);
	import isa_pkg::*;

	instr_t imem [imem_depth];
	logic [mem_addr_w-1:0] pc;
	logic stopped;

	// Program load only while the core is in reset
	always_ff @(posedge clk) begin
		if (rst && prog_we) begin
			imem[prog_addr] <= prog_data;
		end
	end

	// Once a HALT or illegal op reaches decode, fetching stops for good
	always_ff @(posedge clk) begin
		if (rst) begin
			pc       <= '0;
			stopped  <= 1'b0;
			fd_valid <= 1'b0;
		end else if (stopped || halt_seen) begin
			stopped  <= 1'b1;
			fd_valid <= 1'b0;
		end else begin
			pc       <= pc + mem_addr_w'(1);
			fd_valid <= 1'b1;
		end
	end

	// Synchronous read at the current PC
	always_ff @(posedge clk) begin
		fd_instr <= imem[pc];
	end

	load_only_in_reset : assert property (
		@(posedge clk)
		prog_we |-> rst
	) else $error("fetch: program port written outside reset");

endmodule

// File: verilog/decode.sv
// Decode stage: instruction decode, register file with write bypass,
// and the decode/execute register
module decode (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           fd_valid,
	input  isa_pkg::instr_t                fd_instr,
	input  logic                           wb_en,
	input  logic [isa_pkg::reg_addr_w-1:0] wb_reg,
	input  logic [isa_pkg::word_w-1:0]     wb_data,
	output logic                           halt_seen,
	output logic                           dx_valid,
	output pipe_pkg::alu_op_t              dx_alu_op,
	output logic [isa_pkg::word_w-1:0]     dx_a,
	output logic [isa_pkg::word_w-1:0]     dx_b,
	output logic [isa_pkg::word_w-1:0]     dx_st_data,
	output logic [isa_pkg::reg_addr_w-1:0] dx_rs,
	output logic                           dx_rt_used,
	output logic [isa_pkg::reg_addr_w-1:0] dx_rt,
	output logic [isa_pkg::reg_addr_w-1:0] dx_dest,
	output logic                           dx_reg_we,
	output logic                           dx_mem_we,
	output pipe_pkg::res_src_t             dx_res_src,
	output logic                           dx_halt,
	output logic                           dx_illegal,
	output logic                           dx_use_imm
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic [word_w-1:0] regs [2**reg_addr_w];
	logic [reg_addr_w-1:0] rs_sel, rt_sel, dest_sel;
	logic [word_w-1:0] imm_sext, imm_zext, imm_val, rd_a, rd_b;
	logic dec_use_imm, dec_rt_used, dec_reg_we, dec_mem_we, dec_halt, dec_illegal;
	alu_op_t dec_alu_op;
	res_src_t dec_res_src;

	assign imm_sext = {{(word_w-imm_w){fd_instr.i.imm[imm_w-1]}}, fd_instr.i.imm};
	assign imm_zext = {{(word_w-imm_w){1'b0}}, fd_instr.i.imm};

	// Opcode picks the instruction format
	always_comb begin
		rs_sel      = fd_instr.i.rs;
		rt_sel      = fd_instr.i.rd;
		dest_sel    = fd_instr.i.rd;
		imm_val     = imm_sext;
		dec_alu_op  = alu_add;
		dec_res_src = res_alu;
		dec_use_imm = 1'b1;
		dec_rt_used = 1'b0;
		dec_reg_we  = 1'b0;
		dec_mem_we  = 1'b0;
		dec_halt    = 1'b0;
		dec_illegal = 1'b0;
		case (fd_instr.r.opcode)
			op_halt: dec_halt = 1'b1;
			op_nop: begin
			end
			op_addi: dec_reg_we = 1'b1;
			op_subi: begin
				dec_alu_op = alu_sub_rev;
				dec_reg_we = 1'b1;
			end
			op_xori: begin
				dec_alu_op = alu_xor;
				imm_val    = imm_zext;
				dec_reg_we = 1'b1;
			end
			op_andni: begin
				dec_alu_op = alu_andn;
				imm_val    = imm_zext;
				dec_reg_we = 1'b1;
			end
			// Store data comes from the rd field
			op_st: begin
				dec_rt_used = 1'b1;
				dec_mem_we  = 1'b1;
			end
			op_ld: begin
				dec_res_src = res_mem;
				dec_reg_we  = 1'b1;
			end
			op_rrr: begin
				rs_sel      = fd_instr.r.rs;
				rt_sel      = fd_instr.r.rt;
				dest_sel    = fd_instr.r.rd;
				dec_use_imm = 1'b0;
				dec_rt_used = 1'b1;
				dec_reg_we  = 1'b1;
				case (fd_instr.r.funct)
					fn_add:  dec_alu_op = alu_add;
					fn_sub:  dec_alu_op = alu_sub_rev;
					fn_xor:  dec_alu_op = alu_xor;
					fn_andn: dec_alu_op = alu_andn;
				endcase
			end
			default: dec_illegal = 1'b1;
		endcase
	end

	assign halt_seen = fd_valid && (dec_halt || dec_illegal);

	// Register file, a write in this cycle is seen by this cycle's reads
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**reg_addr_w; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en) begin
			regs[wb_reg] <= wb_data;
		end
	end

	assign rd_a = (wb_en && wb_reg == rs_sel) ? wb_data : regs[rs_sel];
	assign rd_b = (wb_en && wb_reg == rt_sel) ? wb_data : regs[rt_sel];

	always_ff @(posedge clk) begin
		if (rst) begin
			dx_valid   <= 1'b0;
			dx_reg_we  <= 1'b0;
			dx_mem_we  <= 1'b0;
			dx_halt    <= 1'b0;
			dx_illegal <= 1'b0;
		end else begin
			dx_valid   <= fd_valid;
			dx_reg_we  <= fd_valid && dec_reg_we;
			dx_mem_we  <= fd_valid && dec_mem_we;
			dx_halt    <= fd_valid && dec_halt;
			dx_illegal <= fd_valid && dec_illegal;
		end
	end

	// Operands and register indices
	always_ff @(posedge clk) begin
		dx_alu_op  <= dec_alu_op;
		dx_a       <= rd_a;
		dx_b       <= dec_use_imm ? imm_val : rd_b;
		dx_st_data <= rd_b;
		dx_rs      <= rs_sel;
		dx_rt      <= rt_sel;
		dx_rt_used <= dec_rt_used;
		dx_dest    <= dest_sel;
		dx_res_src <= dec_res_src;
		dx_use_imm <= dec_use_imm;
	end

	// Fetch must have stopped, so nothing that writes follows a halt
	no_write_after_halt : assert property (
		@(posedge clk) disable iff (rst)
		halt_seen |-> ##2 !(dx_valid && dx_reg_we)
	) else $error("decode: register write decoded after halt_seen");

endmodule

// File: verilog/execute.sv
// Execute stage: forwarding from the result stage, ALU,
// and the execute/result register
module execute (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           dx_valid,
	input  pipe_pkg::alu_op_t              dx_alu_op,
	input  logic [isa_pkg::word_w-1:0]     dx_a,
	input  logic [isa_pkg::word_w-1:0]     dx_b,
	input  logic [isa_pkg::word_w-1:0]     dx_st_data,
	input  logic [isa_pkg::reg_addr_w-1:0] dx_rs,
	input  logic                           dx_rt_used,
	input  logic [isa_pkg::reg_addr_w-1:0] dx_rt,
	input  logic [isa_pkg::reg_addr_w-1:0] dx_dest,
	input  logic                           dx_reg_we,
	input  logic                           dx_mem_we,
	input  pipe_pkg::res_src_t             dx_res_src,
	input  logic                           dx_halt,
	input  logic                           dx_illegal,
	input  logic                           dx_use_imm,
	input  logic                           wb_en,
	input  logic [isa_pkg::reg_addr_w-1:0] wb_reg,
	input  logic [isa_pkg::word_w-1:0]     wb_data,
	output logic                           xr_valid,
	output logic [isa_pkg::word_w-1:0]     xr_alu,
	output logic [isa_pkg::word_w-1:0]     xr_st_data,
	output logic [isa_pkg::reg_addr_w-1:0] xr_dest,
	output logic                           xr_reg_we,
	output logic                           xr_mem_we,
	output pipe_pkg::res_src_t             xr_res_src,
	output logic                           xr_halt,
	output logic                           xr_illegal
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic fwd_rs, fwd_rt;
	logic [word_w-1:0] op_a, op_b, st_data, alu_out;

	assign fwd_rs = wb_en && wb_reg == dx_rs;
	assign fwd_rt = wb_en && dx_rt_used && wb_reg == dx_rt;

	// Immediate operand is never replaced
	assign op_a    = fwd_rs ? wb_data : dx_a;
	assign op_b    = (fwd_rt && !dx_use_imm) ? wb_data : dx_b;
	assign st_data = fwd_rt ? wb_data : dx_st_data;

	always_comb begin
		case (dx_alu_op)
			alu_add:     alu_out = op_a + op_b;
			alu_sub_rev: alu_out = op_b - op_a;
			alu_xor:     alu_out = op_a ^ op_b;
			alu_andn:    alu_out = op_a & ~op_b;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			xr_valid   <= 1'b0;
			xr_reg_we  <= 1'b0;
			xr_mem_we  <= 1'b0;
			xr_halt    <= 1'b0;
			xr_illegal <= 1'b0;
		end else begin
			xr_valid   <= dx_valid;
			xr_reg_we  <= dx_reg_we;
			xr_mem_we  <= dx_mem_we;
			xr_halt    <= dx_halt;
			xr_illegal <= dx_illegal;
		end
	end

	always_ff @(posedge clk) begin
		xr_alu     <= alu_out;
		xr_st_data <= st_data;
		xr_dest    <= dx_dest;
		xr_res_src <= dx_res_src;
	end

	store_or_write : assert property (
		@(posedge clk) disable iff (rst)
		!(xr_mem_we && xr_reg_we)
	) else $error("execute: store and register write in the same instruction");

endmodule

// File: verilog/result.sv
// Result stage with the data memory, write-back select and the sticky halt/err flags
// Everything but the store, halt and err is combinational
module result (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           xr_valid,
	input  logic [isa_pkg::word_w-1:0]     xr_alu,
	input  logic [isa_pkg::word_w-1:0]     xr_st_data,
	input  logic [isa_pkg::reg_addr_w-1:0] xr_dest,
	input  logic                           xr_reg_we,
	input  logic                           xr_mem_we,
	input  pipe_pkg::res_src_t             xr_res_src,
	input  logic                           xr_halt,
	input  logic                           xr_illegal,
	output logic                           wb_en,
	output logic [isa_pkg::reg_addr_w-1:0] wb_reg,
	output logic [isa_pkg::word_w-1:0]     wb_data,
	output logic                           halt,
	output logic                           err
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic [word_w-1:0] dmem [dmem_depth];
	logic [mem_addr_w-1:0] dmem_idx;
	logic mem_access, fault;

	// Word index from the byte address
	assign dmem_idx   = xr_alu[mem_addr_w:1];
	assign mem_access = xr_valid && (xr_mem_we || xr_res_src == res_mem);
	assign fault      = mem_access && xr_alu[0];

	// Nothing retires once halted, and a faulting access writes nothing
	assign wb_en   = xr_valid && xr_reg_we && !fault && !halt;
	assign wb_reg  = xr_dest;
	assign wb_data = (xr_res_src == res_mem) ? dmem[dmem_idx] : xr_alu;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < dmem_depth; i++) begin
				dmem[i] <= '0;
			end
		end else if (xr_valid && xr_mem_we && !fault && !halt) begin
			dmem[dmem_idx] <= xr_st_data;
		end
	end

	// Sticky until the next reset
	always_ff @(posedge clk) begin
		if (rst) begin
			halt <= 1'b0;
			err  <= 1'b0;
		end else begin
			halt <= halt || (xr_valid && (xr_halt || xr_illegal || fault));
			err  <= err || (xr_valid && (xr_illegal || fault));
		end
	end

	// Fetch stops at a HALT or illegal op, so nothing valid follows it
	nothing_after_halt : assert property (
		@(posedge clk) disable iff (rst)
		xr_valid && (xr_halt || xr_illegal) |=> !xr_valid
	) else $error("result: valid instruction after a HALT or illegal op");

endmodule

// File: verilog/proc.sv
// Top level of the four-stage pipelined core
// Load the program while rst is high, then watch wb_en and halt
module proc (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           prog_we,
	input  logic [isa_pkg::mem_addr_w-1:0] prog_addr,
	input  isa_pkg::instr_t                prog_data,
	output logic                           wb_en,
	output logic [isa_pkg::reg_addr_w-1:0] wb_reg,
	output logic [isa_pkg::word_w-1:0]     wb_data,
	output logic                           halt,
	output logic                           err
);
	import isa_pkg::*;
	import pipe_pkg::*;

	// Fetch to decode
	logic fd_valid, halt_seen;
	instr_t fd_instr;

	// Decode to execute
	logic dx_valid, dx_rt_used, dx_reg_we, dx_mem_we, dx_halt, dx_illegal, dx_use_imm;
	logic [word_w-1:0] dx_a, dx_b, dx_st_data;
	logic [reg_addr_w-1:0] dx_rs, dx_rt, dx_dest;
	alu_op_t dx_alu_op;
	res_src_t dx_res_src;

	// Execute to result
	logic xr_valid, xr_reg_we, xr_mem_we, xr_halt, xr_illegal;
	logic [word_w-1:0] xr_alu, xr_st_data;
	logic [reg_addr_w-1:0] xr_dest;
	res_src_t xr_res_src;

	fetch i_fetch (
		.clk(clk), .rst(rst),
		.prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
		.halt_seen(halt_seen),
		.fd_valid(fd_valid), .fd_instr(fd_instr)
	);

	decode i_decode (
		.clk(clk), .rst(rst),
		.fd_valid(fd_valid), .fd_instr(fd_instr),
		.wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data),
		.halt_seen(halt_seen),
		.dx_valid(dx_valid), .dx_alu_op(dx_alu_op),
		.dx_a(dx_a), .dx_b(dx_b), .dx_st_data(dx_st_data),
		.dx_rs(dx_rs), .dx_rt_used(dx_rt_used), .dx_rt(dx_rt), .dx_dest(dx_dest),
		.dx_reg_we(dx_reg_we), .dx_mem_we(dx_mem_we), .dx_res_src(dx_res_src),
		.dx_halt(dx_halt), .dx_illegal(dx_illegal), .dx_use_imm(dx_use_imm)
	);

	execute i_execute (
		.clk(clk), .rst(rst),
		.dx_valid(dx_valid), .dx_alu_op(dx_alu_op),
		.dx_a(dx_a), .dx_b(dx_b), .dx_st_data(dx_st_data),
		.dx_rs(dx_rs), .dx_rt_used(dx_rt_used), .dx_rt(dx_rt), .dx_dest(dx_dest),
		.dx_reg_we(dx_reg_we), .dx_mem_we(dx_mem_we), .dx_res_src(dx_res_src),
		.dx_halt(dx_halt), .dx_illegal(dx_illegal), .dx_use_imm(dx_use_imm),
		.wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data),
		.xr_valid(xr_valid), .xr_alu(xr_alu), .xr_st_data(xr_st_data),
		.xr_dest(xr_dest), .xr_reg_we(xr_reg_we), .xr_mem_we(xr_mem_we),
		.xr_res_src(xr_res_src), .xr_halt(xr_halt), .xr_illegal(xr_illegal)
	);

	result i_result (
		.clk(clk), .rst(rst),
		.xr_valid(xr_valid), .xr_alu(xr_alu), .xr_st_data(xr_st_data),
		.xr_dest(xr_dest), .xr_reg_we(xr_reg_we), .xr_mem_we(xr_mem_we),
		.xr_res_src(xr_res_src), .xr_halt(xr_halt), .xr_illegal(xr_illegal),
		.wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data),
		.halt(halt), .err(err)
	);

endmodule

// File: verif/proc_tb.sv
// Testbench for the pipelined core: runs directed and random programs and checks
// every register write and the final err flag against an ISA reference model
module proc_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import isa_pkg::*;

	logic clk = 1'b0;
	logic rst, prog_we;
	logic [mem_addr_w-1:0] prog_addr;
	instr_t prog_data;
	logic wb_en, halt, err;
	logic [reg_addr_w-1:0] wb_reg;
	logic [word_w-1:0] wb_data;

	// All programs back to back, with start and length per test
	instr_t prog_mem [$];
	int prog_start [$];
	int prog_len [$];
	string test_name [$];
	logic [reg_addr_w-1:0] exp_reg [$];
	logic [word_w-1:0] exp_data [$];
	int test_errs, extra_writes, n_fail;
	int limit_cycles = 0;

	proc DUT (
		.clk(clk), .rst(rst),
		.prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
		.wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data),
		.halt(halt), .err(err)
	);

	always #4 clk = ~clk;

	function automatic instr_t imm_word(input logic [op_w-1:0] op, input int rs, input int rd,
			input int imm);
		instr_t w;
		w.i = '{op, reg_addr_w'(rs), reg_addr_w'(rd), imm_w'(imm)};
		return w;
	endfunction

	function automatic instr_t reg_word(input logic [fn_w-1:0] fn, input int rs, input int rt,
			input int rd);
		instr_t w;
		w.r = '{op_rrr, reg_addr_w'(rs), reg_addr_w'(rt), reg_addr_w'(rd), fn};
		return w;
	endfunction

	function automatic void begin_prog(input string name);
		test_name.push_back(name);
		prog_start.push_back(prog_mem.size());
		prog_len.push_back(0);
	endfunction

	function automatic void emit(input instr_t w);
		prog_mem.push_back(w);
		prog_len[prog_len.size()-1] += 1;
	endfunction

	// ISA reference: fills the expected write list and returns the expected err
	function automatic bit run_model(input int base, input int len);
		logic [word_w-1:0] rf [2**reg_addr_w];
		logic [word_w-1:0] mem [dmem_depth];
		logic [word_w-1:0] a, b, sx, zx, addr, val;
		logic [reg_addr_w-1:0] dest;
		instr_t w;
		bit stop, bad, wr;
		stop = 1'b0;
		bad = 1'b0;
		foreach (rf[k])
			rf[k] = '0;
		foreach (mem[k])
			mem[k] = '0;
		for (int pc = 0; pc < len && !stop; pc++) begin
			w = prog_mem[base + pc];
			a = rf[w.i.rs];
			b = rf[w.r.rt];
			sx = {{(word_w-imm_w){w.i.imm[imm_w-1]}}, w.i.imm};
			zx = {{(word_w-imm_w){1'b0}}, w.i.imm};
			addr = a + sx;
			dest = (w.i.opcode == op_rrr) ? w.r.rd : w.i.rd;
			wr = 1'b1;
			case (w.i.opcode)
				op_addi:  val = a + sx;
				op_subi:  val = sx - a;
				op_xori:  val = a ^ zx;
				op_andni: val = a & ~zx;
				op_rrr: begin
					case (w.r.funct)
						fn_add:  val = a + b;
						fn_sub:  val = b - a;
						fn_xor:  val = a ^ b;
						default: val = a & ~b;
					endcase
				end
				// Word memory at even byte addresses, rd field holds the data register
				op_ld, op_st: begin
					bad = addr[0];
					stop = addr[0];
					wr = !addr[0] && w.i.opcode == op_ld;
					if (!addr[0] && w.i.opcode == op_st) begin
						mem[addr[mem_addr_w:1]] = rf[w.i.rd];
					end
					val = mem[addr[mem_addr_w:1]];
				end
				op_nop: wr = 1'b0;
				op_halt: begin
					wr = 1'b0;
					stop = 1'b1;
				end
				default: begin
					wr = 1'b0;
					stop = 1'b1;
					bad = 1'b1;
				end
			endcase
			if (wr) begin
				rf[dest] = val;
				exp_reg.push_back(dest);
				exp_data.push_back(val);
			end
		end
		return bad;
	endfunction

	// r0 is never written, so loads and stores based on it stay even
	function automatic void add_random_prog(input int n);
		int rs, rt, rd, imm;
		begin_prog($sformatf("random_%0d", n));
		repeat (59) begin
			rs = $urandom_range(0, 7);
			rt = $urandom_range(0, 7);
			rd = $urandom_range(1, 7);
			imm = $urandom_range(0, 31);
			case ($urandom_range(0, 8))
				0: emit(imm_word(op_addi, rs, rd, imm));
				1: emit(imm_word(op_subi, rs, rd, imm));
				2: emit(imm_word(op_xori, rs, rd, imm));
				3: emit(imm_word(op_andni, rs, rd, imm));
				4, 5: emit(reg_word(fn_w'($urandom_range(0, 3)), rs, rt, rd));
				6: emit(imm_word(op_ld, 0, rd, imm & 30));
				7: emit(imm_word(op_st, 0, rs, imm & 30));
				default: emit(imm_word(op_nop, 0, 0, 0));
			endcase
		end
		emit(imm_word(op_halt, 0, 0, 0));
	endfunction

	function automatic void build_programs();
		begin_prog("reg_ops");
		emit(imm_word(op_addi, 0, 1, 13));
		emit(imm_word(op_addi, 0, 2, -6));
		emit(imm_word(op_xori, 0, 3, 27));
		emit(reg_word(fn_add, 1, 2, 4));
		emit(reg_word(fn_sub, 1, 2, 5));
		emit(reg_word(fn_xor, 2, 3, 6));
		emit(reg_word(fn_andn, 2, 3, 7));
		emit(reg_word(fn_sub, 3, 1, 0));
		emit(imm_word(op_halt, 0, 0, 0));
		// Sign extension for ADDI and SUBI, zero extension for XORI and ANDNI
		begin_prog("imm_ops");
		emit(imm_word(op_addi, 0, 1, -16));
		emit(imm_word(op_addi, 1, 2, 15));
		emit(imm_word(op_subi, 2, 3, -1));
		emit(imm_word(op_subi, 1, 4, 7));
		emit(imm_word(op_xori, 1, 5, 31));
		emit(imm_word(op_andni, 1, 6, 21));
		emit(imm_word(op_andni, 2, 7, 16));
		emit(imm_word(op_halt, 0, 0, 0));
		// Dependencies at distance one and two, load then use
		begin_prog("forward");
		emit(imm_word(op_addi, 0, 1, 5));
		emit(imm_word(op_addi, 1, 2, 3));
		emit(reg_word(fn_add, 1, 2, 3));
		emit(reg_word(fn_xor, 3, 2, 1));
		emit(reg_word(fn_sub, 1, 1, 4));
		emit(imm_word(op_st, 0, 3, 4));
		emit(imm_word(op_ld, 0, 5, 4));
		emit(imm_word(op_addi, 5, 6, 1));
		emit(reg_word(fn_andn, 5, 6, 7));
		emit(imm_word(op_st, 6, 7, 0));
		emit(imm_word(op_ld, 6, 1, 0));
		emit(reg_word(fn_add, 1, 1, 2));
		emit(imm_word(op_halt, 0, 0, 0));
		begin_prog("mem");
		emit(imm_word(op_addi, 0, 1, 8));
		emit(imm_word(op_addi, 0, 2, 11));
		emit(imm_word(op_addi, 0, 3, -9));
		emit(imm_word(op_xori, 0, 4, 30));
		emit(imm_word(op_st, 1, 2, 0));
		emit(imm_word(op_st, 1, 3, 2));
		emit(imm_word(op_st, 1, 4, -8));
		emit(imm_word(op_ld, 1, 5, 0));
		emit(imm_word(op_ld, 1, 6, 2));
		emit(imm_word(op_ld, 1, 7, -8));
		emit(imm_word(op_ld, 1, 2, 4));
		emit(imm_word(op_halt, 0, 0, 0));
		for (int n = 0; n < 4; n++) begin
			add_random_prog(n);
		end
		// Opcode 5'b11111 is not part of the ISA
		begin_prog("illegal");
		emit(imm_word(op_addi, 0, 1, 3));
		emit(imm_word(op_addi, 1, 2, 1));
		emit(imm_word(5'b11111, 0, 0, 0));
		emit(imm_word(op_addi, 0, 3, 1));
		emit(imm_word(op_halt, 0, 0, 0));
		begin_prog("ld_odd");
		emit(imm_word(op_addi, 0, 1, 6));
		emit(imm_word(op_ld, 1, 2, 1));
		emit(imm_word(op_addi, 0, 3, 2));
		emit(reg_word(fn_add, 1, 1, 4));
		emit(imm_word(op_halt, 0, 0, 0));
		begin_prog("st_odd");
		emit(imm_word(op_addi, 0, 1, 5));
		emit(imm_word(op_st, 1, 1, 0));
		emit(imm_word(op_ld, 0, 2, 4));
		emit(imm_word(op_addi, 0, 3, 1));
		emit(imm_word(op_halt, 0, 0, 0));
	endfunction

	task automatic run_test(input int t);
		bit exp_err;
		int n_exp;
		exp_reg.delete();
		exp_data.delete();
		exp_err = run_model(prog_start[t], prog_len[t]);
		n_exp = exp_reg.size();
		test_errs = 0;
		extra_writes = 0;
		@(posedge clk);
		#1;
		rst = 1'b1;
		for (int a = 0; a < prog_len[t]; a++) begin
			prog_we = 1'b1;
			prog_addr = mem_addr_w'(a);
			prog_data = prog_mem[prog_start[t] + a];
			@(posedge clk);
			#1;
		end
		prog_we = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		while (halt !== 1'b1) begin
			@(negedge clk);
		end
		// Late writes would still show up in these cycles
		repeat (3) @(negedge clk);
		assert (err === exp_err) else begin
			$display("ERR err exp %h got %h", exp_err, err);
			test_errs++;
		end
		assert (exp_reg.size() == 0) else begin
			$display("%0d expected register writes never happened", exp_reg.size());
			test_errs++;
		end
		assert (extra_writes == 0) else begin
			$display("%0d register writes beyond the expected ones", extra_writes);
			test_errs++;
		end
		if (test_errs != 0) begin
			n_fail++;
		end
		$display("%s: %s, %0d writes, err %0b", test_name[t], (test_errs == 0) ? "pass" : "fail",
			n_exp, exp_err);
	endtask

	// Sampled mid-cycle, where the result stage outputs are settled
	always @(negedge clk) begin
		if (!rst && wb_en) begin
			if (exp_reg.size() == 0) begin
				extra_writes++;
			end else begin
				assert (wb_reg === exp_reg[0]) else begin
					$display("ERR wb_reg exp %h got %h", exp_reg[0], wb_reg);
					test_errs++;
				end
				assert (wb_data === exp_data[0]) else begin
					$display("ERR wb_data exp %h got %h", exp_data[0], wb_data);
					test_errs++;
				end
				void'(exp_reg.pop_front());
				void'(exp_data.pop_front());
			end
		end
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("Timeout: the core did not halt within %0d cycles", limit_cycles);
		$display("Test FAILED");
		$finish;
	end

	initial begin
		int cycles;
		void'($urandom(32'h64ec_7a5b));
		rst = 1'b1;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		n_fail = 0;
		cycles = 0;
		build_programs();
		// Loading and running each take about one cycle per word
		foreach (prog_len[t])
			cycles += 2 * prog_len[t] + 20;
		limit_cycles = cycles;
		foreach (prog_len[t])
			run_test(t);
		$display("%0d tests run, %0d passed, %0d failed", prog_len.size(),
			prog_len.size() - n_fail, n_fail);
		if (n_fail == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// File: proc.f
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/fetch.sv
verilog/decode.sv
verilog/execute.sv
verilog/result.sv
verilog/proc.sv
verif/proc_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= proc_tb
FILELIST  ?= proc.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Test OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
